/* rvCore.f */
rvPkg.sv
immGen.sv
execUnit.sv
regFile.sv
dataMem.sv
rvCore.sv
rvCore_asserts.sv
rvCore_tb.sv

/* Makefile */
TOP = rvCore_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f rvCore.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

/* rvCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore_tb import rvPkg::*; ();

    localparam int   nRows        = 58;
    localparam int   timeoutLimit = nRows * 4 + 20;
    localparam instT ebreakInst   = 32'h0010_0073;

    typedef struct packed {
        instT       inst;
        xlenT       pc;
        logic       wen;
        logic [4:0] rd;
        xlenT       wdata;
        logic       retires;
    } rowT;

    logic       clk;
    logic       arstN;
    logic       imemWe;
    logic [5:0] imemAddr;
    instT       imemData;
    logic       run;
    retireT     retire;
    logic       halted;

    rowT prog [nRows];
    int  nFill;
    int  retIdx;
    int  gap;
    int  cycles;
    bit  running;
    bit  lastRun;
    bit  haltExp;

    rvCore u_rvCore (
        .clk      (clk),
        .arstN    (arstN),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .run      (run),
        .retire   (retire),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic instT rType(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd,
                                   logic [6:0] op);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instT iType(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instT sType(int off, int rs2, int rs1, logic [2:0] f3);
        return {off[11:5], rs2[4:0], rs1[4:0], f3, off[4:0], opStore};
    endfunction

    function automatic instT bType(int off, int rs2, int rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic instT uType(int imm, int rd, logic [6:0] op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic instT jType(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    task automatic checkVal(string name, xlenT got, xlenT exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic expectRow(instT inst, logic wen, int rd, xlenT wdata);
        prog[nFill].inst    = inst;
        prog[nFill].pc      = 64'(nFill * 4);
        prog[nFill].wen     = wen;
        prog[nFill].rd      = rd[4:0];
        prog[nFill].wdata   = wdata;
        prog[nFill].retires = 1'b1;
        nFill++;
    endtask

    task automatic skipRow(instT inst);
        expectRow(inst, 1'b0, 0, '0);
        prog[nFill-1].retires = 1'b0;  // jumped over so never retires
    endtask

    // x1 = 5 and x2 = -3 feed most of the arithmetic
    task automatic buildProgram();
        expectRow(iType(5, 0, f3AddSub, 1, opImm), 1'b1, 1, 64'd5);
        expectRow(iType(-3, 0, f3AddSub, 2, opImm), 1'b1, 2, 64'hFFFF_FFFF_FFFF_FFFD);
        expectRow(rType(f7Base, 2, 1, f3AddSub, 3, opReg), 1'b1, 3, 64'd2);
        expectRow(rType(f7Alt, 2, 1, f3AddSub, 4, opReg), 1'b1, 4, 64'd8);
        expectRow(rType(f7Base, 2, 1, f3And, 5, opReg), 1'b1, 5, 64'd5);
        expectRow(rType(f7Base, 2, 1, f3Or, 6, opReg), 1'b1, 6, 64'hFFFF_FFFF_FFFF_FFFD);
        expectRow(rType(f7Base, 2, 1, f3Xor, 7, opReg), 1'b1, 7, 64'hFFFF_FFFF_FFFF_FFF8);
        expectRow(rType(f7Base, 1, 2, f3Slt, 8, opReg), 1'b1, 8, 64'd1);
        expectRow(rType(f7Base, 1, 2, f3Sltu, 9, opReg), 1'b1, 9, 64'd0);
        expectRow(rType(f7Mul, 2, 1, f3AddSub, 10, opReg), 1'b1, 10, 64'hFFFF_FFFF_FFFF_FFF1);
        expectRow(iType(33, 1, f3Sll, 11, opImm), 1'b1, 11, 64'h0000_000A_0000_0000);
        expectRow(iType('h401, 2, f3Srl, 12, opImm), 1'b1, 12, 64'hFFFF_FFFF_FFFF_FFFE);
        expectRow(iType(60, 2, f3Srl, 13, opImm), 1'b1, 13, 64'h0000_0000_0000_000F);
        expectRow(rType(f7Base, 1, 1, f3Sll, 14, opReg), 1'b1, 14, 64'h0000_0000_0000_00A0);
        expectRow(rType(f7Alt, 1, 2, f3Srl, 15, opReg), 1'b1, 15, 64'hFFFF_FFFF_FFFF_FFFF);
        expectRow(rType(f7Base, 1, 10, f3Srl, 16, opReg), 1'b1, 16, 64'h07FF_FFFF_FFFF_FFFF);
        expectRow(iType(6, 1, f3Sltu, 17, opImm), 1'b1, 17, 64'd1);
        expectRow(iType('hF0, 2, f3And, 18, opImm), 1'b1, 18, 64'h0000_0000_0000_00F0);
        expectRow(iType(-16, 1, f3Or, 19, opImm), 1'b1, 19, 64'hFFFF_FFFF_FFFF_FFF5);
        expectRow(iType(-1, 1, f3Xor, 20, opImm), 1'b1, 20, 64'hFFFF_FFFF_FFFF_FFFA);
        expectRow(iType(7, 1, f3AddSub, 0, opImm), 1'b0, 0, '0);  // x0 target
        expectRow(uType('h80000, 21, opLui), 1'b1, 21, 64'hFFFF_FFFF_8000_0000);
        expectRow(uType(1, 22, opAuipc), 1'b1, 22, 64'h0000_0000_0000_1058);
        expectRow(iType(-1, 21, f3AddSub, 23, opImmW), 1'b1, 23, 64'h0000_0000_7FFF_FFFF);
        expectRow(rType(f7Base, 2, 1, f3AddSub, 24, opRegW), 1'b1, 24, 64'd2);
        expectRow(rType(f7Alt, 1, 2, f3AddSub, 25, opRegW), 1'b1, 25, 64'hFFFF_FFFF_FFFF_FFF8);
        expectRow(rType(f7Base, 1, 23, f3Sll, 26, opRegW), 1'b1, 26, 64'hFFFF_FFFF_FFFF_FFE0);
        expectRow(rType(f7Base, 1, 21, f3Srl, 27, opRegW), 1'b1, 27, 64'h0000_0000_0400_0000);
        expectRow(rType(f7Alt, 1, 21, f3Srl, 28, opRegW), 1'b1, 28, 64'hFFFF_FFFF_FC00_0000);
        expectRow(rType(f7Mul, 22, 22, f3AddSub, 29, opRegW), 1'b1, 29, 64'h0000_0000_010B_1E40);
        expectRow(iType('h404, 21, f3Srl, 30, opImmW), 1'b1, 30, 64'hFFFF_FFFF_F800_0000);
        expectRow(sType(64, 10, 0, f3Dbl), 1'b0, 0, '0);
        expectRow(sType(65, 1, 0, f3Byte), 1'b0, 0, '0);
        expectRow(sType(66, 18, 0, f3Half), 1'b0, 0, '0);
        expectRow(sType(68, 21, 0, f3Word), 1'b0, 0, '0);
        // bytes 64..71 now F1 05 F0 00 00 00 00 80
        expectRow(iType(64, 0, f3Dbl, 3, opLoad), 1'b1, 3, 64'h8000_0000_00F0_05F1);
        expectRow(iType(64, 0, f3Byte, 4, opLoad), 1'b1, 4, 64'hFFFF_FFFF_FFFF_FFF1);
        expectRow(iType(64, 0, f3ByteU, 5, opLoad), 1'b1, 5, 64'h0000_0000_0000_00F1);
        expectRow(iType(70, 0, f3Half, 6, opLoad), 1'b1, 6, 64'hFFFF_FFFF_FFFF_8000);
        expectRow(iType(70, 0, f3HalfU, 7, opLoad), 1'b1, 7, 64'h0000_0000_0000_8000);
        expectRow(iType(68, 0, f3Word, 8, opLoad), 1'b1, 8, 64'hFFFF_FFFF_8000_0000);
        expectRow(iType(68, 0, f3WordU, 9, opLoad), 1'b1, 9, 64'h0000_0000_8000_0000);
        expectRow(iType(64, 0, f3Word, 11, opLoad), 1'b1, 11, 64'h0000_0000_00F0_05F1);
        expectRow(bType(8, 2, 1, f3Beq), 1'b0, 0, '0);  // not taken
        expectRow(bType(8, 2, 1, f3Bne), 1'b0, 0, '0);
        skipRow(iType(1, 0, f3AddSub, 31, opImm));
        expectRow(bType(8, 1, 2, f3Blt), 1'b0, 0, '0);
        skipRow(iType(2, 0, f3AddSub, 31, opImm));
        expectRow(bType(8, 1, 2, f3Bge), 1'b0, 0, '0);  // not taken
        expectRow(bType(8, 1, 2, f3Bltu), 1'b0, 0, '0);  // not taken
        expectRow(bType(8, 1, 2, f3Bgeu), 1'b0, 0, '0);
        skipRow(iType(3, 0, f3AddSub, 31, opImm));
        expectRow(jType(8, 12), 1'b1, 12, 64'h0000_0000_0000_00D4);
        skipRow(iType(4, 0, f3AddSub, 31, opImm));
        expectRow(iType(225, 0, 3'b000, 13, opJalr), 1'b1, 13, 64'h0000_0000_0000_00DC);
        skipRow(iType(5, 0, f3AddSub, 31, opImm));
        expectRow(iType(1, 12, f3AddSub, 14, opImm), 1'b1, 14, 64'h0000_0000_0000_00D5);
        expectRow(ebreakInst, 1'b0, 0, '0);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < nRows; i++) begin
            @(negedge clk);
            imemWe   = 1'b1;
            imemAddr = 6'(i);
            imemData = prog[i].inst;
        end
        @(negedge clk);
        imemWe = 1'b0;
    endtask

    // checks the retire trace and picks run for the next edge
    task automatic stepCycle();
        bit newRun;
        @(negedge clk);
        checkVal("retire.valid", 64'(retire.valid), 64'(lastRun));
        if (retire.valid) begin
            while (retIdx < nRows && !prog[retIdx].retires) retIdx++;
            if (retIdx >= nRows) begin
                $display("retire seen after the last program instruction");
                $display("RESULT: FAIL");
                $fatal(1, "extra retire");
            end
            checkVal("retire.pc", retire.pc, prog[retIdx].pc);
            checkVal("retire.rdWen", 64'(retire.rdWen), 64'(prog[retIdx].wen));
            if (prog[retIdx].wen) begin
                checkVal("retire.rd", 64'(retire.rd), 64'(prog[retIdx].rd));
                checkVal("retire.wdata", retire.wdata, prog[retIdx].wdata);
            end
            if (prog[retIdx].inst == ebreakInst) haltExp = 1'b1;
            retIdx++;
        end
        checkVal("halted", 64'(halted), 64'(haltExp));
        if (gap > 0) begin
            newRun = 1'b0;  // stall
            gap--;
        end else begin
            newRun = 1'b1;
            gap = int'($urandom % 4);
        end
        run     = newRun;
        lastRun = newRun && !haltExp;
    endtask

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > timeoutLimit) begin
                $display("timeout: program did not finish within %0d cycles", timeoutLimit);
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        arstN    = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        run      = 1'b0;
        nFill    = 0;
        retIdx   = 0;
        cycles   = 0;
        running  = 1'b0;
        lastRun  = 1'b0;
        haltExp  = 1'b0;
        void'($urandom(18694));
        gap = int'($urandom % 4);
        buildProgram();
        checkVal("program rows", 64'(nFill), 64'(nRows));
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        loadProgram();
        running = 1'b1;
        while (!haltExp) stepCycle();
        repeat (8) stepCycle();  // halted core must stay silent
        checkVal("retired rows", 64'(retIdx), 64'(nRows));
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* rvCore_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore_asserts import rvPkg::*; (
    input logic   clk,
    input logic   arstN,
    input retireT retire,
    input logic   halted
);

    // once halted, the retire trace stays quiet
    noRetireAfterHalt: assert property (
        @(posedge clk) disable iff (!arstN) $past(halted) |-> !retire.valid
    ) else $error("retire.valid high after the core halted");

    pcAligned: assert property (
        @(posedge clk) disable iff (!arstN) retire.valid |-> (retire.pc[1:0] == 2'b00)
    ) else $error("retire.pc is not word aligned");

    quietAfterReset: assert property (
        @(posedge clk) $rose(arstN) |-> !retire.valid
    ) else $error("retire.valid high in the cycle after reset release");

endmodule

bind rvCore rvCore_asserts uAsserts (
    .clk    (clk),
    .arstN  (arstN),
    .retire (retire),
    .halted (halted)
);

`default_nettype wire

/* rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvPkg::*; #(
    parameter int imemWords = 64,
    parameter int dmemBytes = 256
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         imemWe,
    input  logic [$clog2(imemWords)-1:0] imemAddr,
    input  instT                         imemData,
    input  logic                         run,
    output retireT                       retire,
    output logic                         halted
);

    localparam int imemAw = $clog2(imemWords);

    instT       imem [imemWords];
    xlenT       pc;
    instT       inst;
    decodedT    dec;
    xlenT       rs1Val;
    xlenT       rs2Val;
    xlenT       loadAddr;
    xlenT       loadData;
    xlenT       rdData;
    xlenT       nextPc;
    storeReqT   store;
    logic       rdWen;
    logic       isHalt;
    logic       commit;
    logic       retValid;
    xlenT       retPc;
    logic       retRdWen;
    logic [4:0] retRd;
    xlenT       retWdata;

    assign commit = run && !halted;

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign inst = imem[pc[imemAw+1:2]];  // word fetch

    immGen uImmGen (
        .inst (inst),
        .dec  (dec)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .we     (rdWen && commit),
        .waddr  (dec.rd),
        .wdata  (rdData),
        .raddr1 (dec.rs1Idx),
        .raddr2 (dec.rs2Idx),
        .rdata1 (rs1Val),
        .rdata2 (rs2Val)
    );

    execUnit uExecUnit (
        .pc       (pc),
        .dec      (dec),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .loadData (loadData),
        .loadAddr (loadAddr),
        .rdWen    (rdWen),
        .rdData   (rdData),
        .nextPc   (nextPc),
        .store    (store),
        .isHalt   (isHalt)
    );

    dataMem #(.dmemBytes(dmemBytes)) uDataMem (
        .clk      (clk),
        .store    (store),
        .commit   (commit),
        .loadAddr (loadAddr),
        .loadData (loadData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc       <= '0;
            halted   <= 1'b0;
            retValid <= 1'b0;
        end else begin
            retValid <= commit;  // one pulse per commit edge
            if (commit) begin
                pc <= nextPc;
                if (isHalt) begin
                    halted <= 1'b1;  // ebreak
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            retPc    <= pc;
            retRdWen <= rdWen;
            retRd    <= dec.rd;
            retWdata <= rdData;
        end
    end

    assign retire = '{valid: retValid, pc: retPc, rdWen: retRdWen, rd: retRd, wdata: retWdata};

endmodule

`default_nettype wire

/* dataMem.sv */
`timescale 1ns/1ps
`default_nettype none

module dataMem import rvPkg::*; #(
    parameter int dmemBytes = 256
) (
    input  logic     clk,
    input  storeReqT store,
    input  logic     commit,
    input  xlenT     loadAddr,
    output xlenT     loadData
);

    localparam int addrW = $clog2(dmemBytes);

    logic [7:0]       mem [dmemBytes];
    logic [addrW-4:0] wrDw;  // doubleword index that wraps at size
    logic [addrW-4:0] rdDw;

    assign wrDw = store.addr[addrW-1:3];
    assign rdDw = loadAddr[addrW-1:3];

    always_ff @(posedge clk) begin
        if (store.en && commit) begin
            for (int i = 0; i < 8; i++) begin
                if (store.mask[i]) begin
                    mem[{wrDw, 3'(i)}] <= store.data[8*i +: 8];
                end
            end
        end
    end

    for (genvar i = 0; i < 8; i++) begin : gRead
        assign loadData[8*i +: 8] = mem[{rdDw, 3'(i)}];
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       we,
    input  logic [4:0] waddr,
    input  xlenT       wdata,
    input  logic [4:0] raddr1,
    input  logic [4:0] raddr2,
    output xlenT       rdata1,
    output xlenT       rdata2
);

    xlenT regs [32];

    // no writes while reset is asserted
    always_ff @(posedge clk) begin
        if (we && arstN && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];  // x0 reads zero
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvPkg::*; (
    input  xlenT     pc,
    input  decodedT  dec,
    input  xlenT     rs1Val,
    input  xlenT     rs2Val,
    input  xlenT     loadData,
    output xlenT     loadAddr,
    output logic     rdWen,
    output xlenT     rdData,
    output xlenT     nextPc,
    output storeReqT store,
    output logic     isHalt
);

    function automatic xlenT sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    xlenT        opB;
    xlenT        sum;
    xlenT        shl;
    xlenT        shr;
    xlenT        sra;
    xlenT        pcPlus4;
    xlenT        loadShift;
    xlenT        storeAddr;
    logic [31:0] sllW;
    logic [31:0] srlW;
    logic [31:0] sraW;
    logic        useReg;
    logic        lessS;
    logic        lessU;
    logic        hiBase;
    logic        hiAlt;
    logic        brTaken;
    logic        wen;
    logic [7:0]  laneMask;

    assign useReg  = (dec.opcode == opReg) || (dec.opcode == opRegW) || (dec.opcode == opBranch);
    assign opB     = useReg ? rs2Val : dec.immI;
    assign sum     = rs1Val + opB;
    assign shl     = rs1Val << opB[5:0];
    assign shr     = rs1Val >> opB[5:0];
    assign sra     = $signed(rs1Val) >>> opB[5:0];
    assign sllW    = rs1Val[31:0] << opB[4:0];
    assign srlW    = rs1Val[31:0] >> opB[4:0];
    assign sraW    = $signed(rs1Val[31:0]) >>> opB[4:0];
    assign lessS   = $signed(rs1Val) < $signed(opB);
    assign lessU   = rs1Val < opB;
    assign pcPlus4 = pc + 64'd4;

    // funct7[0] is shamt[5] for 64-bit immediate shifts
    assign hiBase = dec.funct7[6:1] == f7Base[6:1];
    assign hiAlt  = dec.funct7[6:1] == f7Alt[6:1];

    assign loadAddr  = rs1Val + dec.immI;
    assign loadShift = loadData >> {loadAddr[2:0], 3'b000};  // wanted bytes to lane 0

    always_comb begin
        wen    = 1'b1;
        rdData = '0;
        case (dec.opcode)
            opLui:   rdData = dec.immU;
            opAuipc: rdData = pc + dec.immU;
            opJal, opJalr: rdData = pcPlus4;  // link
            opImm: begin
                case (dec.funct3)
                    f3AddSub: rdData = sum;
                    f3Sltu:   rdData = xlenT'(lessU);
                    f3And:    rdData = rs1Val & opB;
                    f3Or:     rdData = rs1Val | opB;
                    f3Xor:    rdData = rs1Val ^ opB;
                    f3Sll: begin
                        rdData = shl;
                        wen    = hiBase;
                    end
                    f3Srl: begin
                        rdData = dec.funct7[5] ? sra : shr;
                        wen    = hiBase || hiAlt;
                    end
                    default:  wen = 1'b0;
                endcase
            end
            opImmW: begin
                case ({dec.funct7, dec.funct3})
                    {f7Base, f3Sll}: rdData = sext32(sllW);
                    {f7Base, f3Srl}: rdData = sext32(srlW);
                    {f7Alt, f3Srl}:  rdData = sext32(sraW);
                    default: begin
                        rdData = sext32(sum[31:0]);  // addiw
                        wen    = dec.funct3 == f3AddSub;
                    end
                endcase
            end
            opReg: begin
                case ({dec.funct7, dec.funct3})
                    {f7Base, f3AddSub}: rdData = sum;
                    {f7Alt, f3AddSub}:  rdData = rs1Val - rs2Val;
                    {f7Mul, f3AddSub}:  rdData = rs1Val * rs2Val;
                    {f7Base, f3Sll}:    rdData = shl;
                    {f7Base, f3Slt}:    rdData = xlenT'(lessS);
                    {f7Base, f3Sltu}:   rdData = xlenT'(lessU);
                    {f7Base, f3Xor}:    rdData = rs1Val ^ rs2Val;
                    {f7Base, f3Srl}:    rdData = shr;
                    {f7Alt, f3Srl}:     rdData = sra;
                    {f7Base, f3Or}:     rdData = rs1Val | rs2Val;
                    {f7Base, f3And}:    rdData = rs1Val & rs2Val;
                    default:            wen = 1'b0;
                endcase
            end
            opRegW: begin
                case ({dec.funct7, dec.funct3})
                    {f7Base, f3AddSub}: rdData = sext32(sum[31:0]);
                    {f7Alt, f3AddSub}:  rdData = sext32(rs1Val[31:0] - rs2Val[31:0]);
                    {f7Mul, f3AddSub}:  rdData = sext32(rs1Val[31:0] * rs2Val[31:0]);
                    {f7Base, f3Sll}:    rdData = sext32(sllW);
                    {f7Base, f3Srl}:    rdData = sext32(srlW);
                    {f7Alt, f3Srl}:     rdData = sext32(sraW);
                    default:            wen = 1'b0;
                endcase
            end
            opLoad: begin
                case (dec.funct3)
                    f3Byte:  rdData = {{56{loadShift[7]}}, loadShift[7:0]};
                    f3Half:  rdData = {{48{loadShift[15]}}, loadShift[15:0]};
                    f3Word:  rdData = sext32(loadShift[31:0]);
                    f3Dbl:   rdData = loadShift;
                    f3ByteU: rdData = {56'b0, loadShift[7:0]};
                    f3HalfU: rdData = {48'b0, loadShift[15:0]};
                    f3WordU: rdData = {32'b0, loadShift[31:0]};
                    default: wen = 1'b0;
                endcase
            end
            default: wen = 1'b0;  // stores, branches, system, unknown
        endcase
    end

    assign rdWen  = wen && (dec.rd != 5'd0);
    assign isHalt = (dec.opcode == opSystem) && (dec.funct3 == 3'b000)
                    && (dec.immI[11:0] == 12'h001);

    always_comb begin
        case (dec.funct3)
            f3Beq:   brTaken = rs1Val == rs2Val;
            f3Bne:   brTaken = rs1Val != rs2Val;
            f3Blt:   brTaken = lessS;
            f3Bge:   brTaken = !lessS;
            f3Bltu:  brTaken = lessU;
            f3Bgeu:  brTaken = !lessU;
            default: brTaken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.opcode)
            opJal:    nextPc = pc + dec.immJ;
            opJalr:   nextPc = {sum[63:1], 1'b0};
            opBranch: nextPc = brTaken ? pc + dec.immB : pcPlus4;
            default:  nextPc = pcPlus4;
        endcase
    end

    assign storeAddr = rs1Val + dec.immS;

    always_comb begin
        case (dec.funct3)
            f3Byte:  laneMask = 8'h01;
            f3Half:  laneMask = 8'h03;
            f3Word:  laneMask = 8'h0f;
            f3Dbl:   laneMask = 8'hff;
            default: laneMask = 8'h00;
        endcase
        store.en   = (dec.opcode == opStore) && (laneMask != 8'h00);
        store.addr = storeAddr;
        store.data = rs2Val << {storeAddr[2:0], 3'b000};
        store.mask = laneMask << storeAddr[2:0];
    end

endmodule

`default_nettype wire

/* immGen.sv */
`timescale 1ns/1ps
`default_nettype none

module immGen import rvPkg::*; (
    input  instT    inst,
    output decodedT dec
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        dec.opcode = inst[6:0];
        dec.rd     = inst[11:7];
        dec.funct3 = inst[14:12];
        dec.rs1Idx = inst[19:15];
        dec.rs2Idx = inst[24:20];
        dec.funct7 = inst[31:25];

        dec.immI = {{52{sign}}, inst[31:20]};
        dec.immS = {{52{sign}}, inst[31:25], inst[11:7]};
        dec.immU = {{32{sign}}, inst[31:12], 12'b0};

        // branch offset with bit 0 always zero
        dec.immB = {
            {51{sign}},
            inst[31],
            inst[7],
            inst[30:25],
            inst[11:8],
            1'b0
        };

        // jump offset
        dec.immJ = {
            {43{sign}},
            inst[31],
            inst[19:12],
            inst[20],
            inst[30:21],
            1'b0
        };
    end

endmodule

`default_nettype wire

/* rvPkg.sv */
`default_nettype none

package rvPkg;

    typedef logic [63:0] xlenT;
    typedef logic [31:0] instT;

    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opImmW   = 7'b0011011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opRegW   = 7'b0111011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opSystem = 7'b1110011;

    // alu funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // branch funct3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // load/store width funct3
    localparam logic [2:0] f3Byte  = 3'b000;
    localparam logic [2:0] f3Half  = 3'b001;
    localparam logic [2:0] f3Word  = 3'b010;
    localparam logic [2:0] f3Dbl   = 3'b011;
    localparam logic [2:0] f3ByteU = 3'b100;
    localparam logic [2:0] f3HalfU = 3'b101;
    localparam logic [2:0] f3WordU = 3'b110;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;
    localparam logic [6:0] f7Mul  = 7'b0000001;

    typedef struct packed {
        logic [6:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs1Idx;
        logic [4:0] rs2Idx;
        logic [2:0] funct3;
        logic [6:0] funct7;
        xlenT       immI;
        xlenT       immS;
        xlenT       immB;
        xlenT       immU;
        xlenT       immJ;
    } decodedT;

    typedef struct packed {
        logic       en;
        xlenT       addr;
        xlenT       data;
        logic [7:0] mask;  // one bit per byte lane at its offset
    } storeReqT;

    typedef struct packed {
        logic       valid;
        xlenT       pc;
        logic       rdWen;
        logic [4:0] rd;
        xlenT       wdata;
    } retireT;

endpackage

`default_nettype wire
